/* logic/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and address width
`define XLEN 32

// Register file
`define REG_ADDR_W 5
`define REG_COUNT 32

// Data memory, in words
`define DMEM_DEPTH 256
`define DMEM_ADDR_W 8

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

/* logic/isa_pkg.sv */
`include "cpu_settings.svh"

package isa_pkg;

    // One instruction word in R format or I format
    typedef union packed {
        struct packed {
            logic [5:0]             opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [`REG_ADDR_W-1:0] rd;
            logic [4:0]             shamt;
            logic [5:0]             funct;
        } r;
        struct packed {
            logic [5:0]             opcode;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [15:0]            imm;
        } i;
    } instr_t;

    localparam logic [5:0] OP_RTYPE = 6'b000000;

    // Low three bits of the immediate ALU group pick the operation
    localparam logic [5:0] OP_ORI   = 6'b010000;
    localparam logic [5:0] OP_ANDI  = 6'b010001;
    localparam logic [5:0] OP_XORI  = 6'b010010;
    localparam logic [5:0] OP_ADDI  = 6'b010011;
    localparam logic [5:0] OP_NORI  = 6'b010100;
    localparam logic [5:0] OP_NANDI = 6'b010101;
    localparam logic [5:0] OP_SLTUI = 6'b010110;
    localparam logic [5:0] OP_SUBI  = 6'b010111;

    localparam logic [5:0] OP_LW = 6'b100011;
    localparam logic [5:0] OP_SW = 6'b101011;

    localparam logic [5:0] FN_ALU_MASK = 6'b000111;

endpackage

/* logic/ctrl_pkg.sv */
package ctrl_pkg;

    localparam int ALU_OP_W = 3;

    localparam logic [ALU_OP_W-1:0] ALU_OR   = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_NAND = 3'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 3'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 3'd7;

    // Write-back source
    localparam logic WB_ALU = 1'b0;
    localparam logic WB_MEM = 1'b1;

endpackage

/* logic/stage_ifs.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

// Fetch to decode
interface fd_if;
    logic             valid;
    logic [`XLEN-1:0] instr;

    modport src (output valid, instr);
    modport dst (input valid, instr);
endinterface

// Decode to execute
interface de_if;
    import ctrl_pkg::*;

    logic                   valid;
    logic [ALU_OP_W-1:0]    alu_op;
    logic                   alu_src_imm;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   wb_sel;
    logic [`XLEN-1:0]       rs_data;
    logic [`XLEN-1:0]       rt_data;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] dest;

    modport src (output valid, alu_op, alu_src_imm, reg_write, mem_read, mem_write,
                 wb_sel, rs_data, rt_data, imm, dest);
    modport dst (input valid, alu_op, alu_src_imm, reg_write, mem_read, mem_write,
                 wb_sel, rs_data, rt_data, imm, dest);
endinterface

// Execute to memory
interface em_if;
    logic                   valid;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   wb_sel;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] dest;

    modport src (output valid, reg_write, mem_read, mem_write, wb_sel,
                 alu_result, store_data, dest);
    modport dst (input valid, reg_write, mem_read, mem_write, wb_sel,
                 alu_result, store_data, dest);
endinterface

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             enable,
    output logic [`XLEN-1:0] instr_addr,
    input  logic [`XLEN-1:0] instr_data,
    fd_if.src                fd
);

    logic [`XLEN-1:0] pc;

    // Instruction memory lives outside and answers within the cycle
    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (!reset) begin
            pc       <= `RESET_PC;
            fd.valid <= 1'b0;
            fd.instr <= '0;
        end else if (enable) begin
            pc       <= pc + `XLEN'(4);
            fd.valid <= 1'b1;
            fd.instr <= instr_data;
        end
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    fd_if.dst                      fd,
    input  logic                   rf_we,
    input  logic [`REG_ADDR_W-1:0] rf_waddr,
    input  logic [`XLEN-1:0]       rf_wdata,
    de_if.src                      de
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [`XLEN-1:0]       regs [`REG_COUNT];
    instr_t                 instr;
    logic [ALU_OP_W-1:0]    alu_op;
    logic                   alu_src_imm;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   wb_sel;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0]       imm;

    assign instr = fd.instr;
    assign imm   = {{(`XLEN-16){instr.i.imm[15]}}, instr.i.imm};

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op      = ALU_OR;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        wb_sel      = WB_ALU;
        dest        = instr.r.rd;
        case (instr.i.opcode) inside
            OP_RTYPE: begin
                alu_op    = instr.r.funct[ALU_OP_W-1:0];
                // Only funct codes 0..7 are defined
                reg_write = (instr.r.funct & ~FN_ALU_MASK) == 6'b0;
            end
            [OP_ORI:OP_SUBI]: begin
                alu_op      = instr.i.opcode[ALU_OP_W-1:0];
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                dest        = instr.i.rt;
            end
            OP_LW: begin
                alu_op      = ALU_ADD;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                wb_sel      = WB_MEM;
                dest        = instr.i.rt;
            end
            OP_SW: begin
                alu_op      = ALU_ADD;
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register file with r0 as an ordinary register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int k = 0; k < `REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // Decode to execute register
    always_ff @(posedge clk) begin
        if (!reset) begin
            de.valid     <= 1'b0;
            de.reg_write <= 1'b0;
            de.mem_read  <= 1'b0;
            de.mem_write <= 1'b0;
        end else if (enable) begin
            de.valid     <= fd.valid;
            de.reg_write <= reg_write;
            de.mem_read  <= mem_read;
            de.mem_write <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            de.alu_op      <= alu_op;
            de.alu_src_imm <= alu_src_imm;
            de.wb_sel      <= wb_sel;
            de.rs_data     <= regs[instr.r.rs];
            de.rt_data     <= regs[instr.r.rt];
            de.imm         <= imm;
            de.dest        <= dest;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    de_if.dst    de,
    em_if.src    em
);
    import ctrl_pkg::*;

    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] result;

    assign operand_b = de.alu_src_imm ? de.imm : de.rt_data;

    always_comb begin
        result = '0;
        case (de.alu_op)
            ALU_OR:   result = de.rs_data | operand_b;
            ALU_AND:  result = de.rs_data & operand_b;
            ALU_XOR:  result = de.rs_data ^ operand_b;
            ALU_ADD:  result = de.rs_data + operand_b;
            ALU_NOR:  result = ~(de.rs_data | operand_b);
            ALU_NAND: result = ~(de.rs_data & operand_b);
            // Unsigned compare giving 1 or 0
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, de.rs_data < operand_b};
            ALU_SUB:  result = de.rs_data - operand_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            em.valid     <= 1'b0;
            em.reg_write <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
        end else if (enable) begin
            em.valid     <= de.valid;
            em.reg_write <= de.reg_write;
            em.mem_read  <= de.mem_read;
            em.mem_write <= de.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            em.wb_sel     <= de.wb_sel;
            em.alu_result <= result;
            em.store_data <= de.rt_data;
            em.dest       <= de.dest;
        end
    end

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module memory_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    em_if.dst                      em,
    output logic                   rf_we,
    output logic [`REG_ADDR_W-1:0] rf_waddr,
    output logic [`XLEN-1:0]       rf_wdata,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_reg,
    output logic [`XLEN-1:0]       wb_data
);
    import ctrl_pkg::*;

    logic [`XLEN-1:0]        dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_W-1:0] word_idx;
    logic [`XLEN-1:0]        read_data;
    logic                    mw_reg_write;
    logic                    mw_wb_sel;
    logic [`XLEN-1:0]        mw_alu_result;
    logic [`REG_ADDR_W-1:0]  mw_dest;

    //////////////////////////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////////////////////////

    // Word i starts out holding i
    initial begin
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            dmem[i] = `XLEN'(i);
        end
    end

    // Byte address to word index
    assign word_idx = em.alu_result[`DMEM_ADDR_W+1:2];

    // Read data registers alongside the memory to write-back stage
    always @(posedge clk) begin
        if (enable && em.valid && em.mem_write) begin
            dmem[word_idx] <= em.store_data;
        end
        if (enable && em.mem_read) begin
            read_data <= dmem[word_idx];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory to write-back register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            mw_reg_write <= 1'b0;
        end else if (enable) begin
            // Bubbles never retire
            mw_reg_write <= em.valid & em.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            mw_wb_sel     <= em.wb_sel;
            mw_alu_result <= em.alu_result;
            mw_dest       <= em.dest;
        end
    end

    // A frozen stage stays quiet so each retire reports once
    assign wb_valid = mw_reg_write & enable;
    assign wb_reg   = mw_dest;
    assign wb_data  = (mw_wb_sel == WB_MEM) ? read_data : mw_alu_result;

    assign rf_we    = wb_valid;
    assign rf_waddr = mw_dest;
    assign rf_wdata = wb_data;

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    output logic [`XLEN-1:0]       instr_addr,
    input  logic [`XLEN-1:0]       instr_data,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_reg,
    output logic [`XLEN-1:0]       wb_data
);

    logic                   rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]       rf_wdata;

    fd_if fd ();
    de_if de ();
    em_if em ();

    fetch_stage u_fetch (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .fd         (fd.src)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .fd       (fd.dst),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .de       (de.src)
    );

    execute_stage u_execute (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .de     (de.dst),
        .em     (em.src)
    );

    // Register-file writes loop back to decode
    memory_stage u_memory (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .em       (em.dst),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data)
    );

endmodule

/* sim/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int PROG_LEN = 120;
    // Program length doubled for stalls, plus drain and margin
    localparam int MAX_CYCLES = 1000;

    logic                   clk;
    logic                   reset;
    logic                   enable;
    logic [`XLEN-1:0]       instr_addr;
    logic [`XLEN-1:0]       instr_data;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_reg;
    logic [`XLEN-1:0]       wb_data;

    instr_t                 prog [PROG_LEN];
    logic [`REG_ADDR_W-1:0] exp_reg [PROG_LEN];
    logic [`XLEN-1:0]       exp_data [PROG_LEN];
    int                     exp_k [PROG_LEN];
    int                     due [PROG_LEN];
    logic [`REG_ADDR_W-1:0] recent [3];

    int                     seed;
    int                     n_exp;
    int                     ret_idx;
    int                     en_edges;
    int                     cycles;
    int                     errors;
    int                     stall_left;
    int                     fetch_k;
    int                     front_due;
    logic                   armed;
    logic                   prev_reset;
    logic                   prev_en;
    logic                   done;
    logic [`XLEN-1:0]       prev_addr;
    logic [`XLEN-1:0]       front_data;
    logic [`REG_ADDR_W-1:0] front_reg;
    logic [`XLEN-1:0]       stim_r;

    cpu_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input logic [ALU_OP_W-1:0] op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] res;
        res = '0;
        case (op)
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            ALU_XOR:  res = a ^ b;
            ALU_ADD:  res = a + b;
            ALU_NOR:  res = ~a & ~b;
            ALU_NAND: res = ~a | ~b;
            ALU_SLTU: res = (a < b) ? `XLEN'(1) : '0;
            ALU_SUB:  res = a + ~b + `XLEN'(1);
        endcase
        return res;
    endfunction

    // Source register not written by the last three instructions
    function automatic logic [`REG_ADDR_W-1:0] pick_src();
        logic [`XLEN-1:0] r;
        r = rand32();
        while (r[`REG_ADDR_W-1:0] == recent[0] || r[`REG_ADDR_W-1:0] == recent[1] ||
               r[`REG_ADDR_W-1:0] == recent[2]) begin
            r = rand32();
        end
        return r[`REG_ADDR_W-1:0];
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Random program and reference model
    ////////////////////////////////////////////////////////////////////

    task automatic build_program();
        logic [`XLEN-1:0]        mregs [`REG_COUNT];
        logic [`XLEN-1:0]        mmem [`DMEM_DEPTH];
        logic [`XLEN-1:0]        r;
        logic [`XLEN-1:0]        val;
        logic [ALU_OP_W-1:0]     op;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`REG_ADDR_W-1:0]  dest;
        logic [`DMEM_ADDR_W-1:0] word;
        logic [`DMEM_ADDR_W-1:0] last_store;
        logic                    have_store;
        logic                    writes;
        instr_t                  ins;
        for (int i = 0; i < `REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            mmem[i] = `XLEN'(i);
        end
        recent[0] = '0;
        recent[1] = '0;
        recent[2] = '0;
        have_store = 1'b0;
        last_store = '0;
        for (int k = 0; k < PROG_LEN; k++) begin
            r = rand32();
            op = r[4:2];
            rs = pick_src();
            rt = pick_src();
            // r0 stays zero and serves as the load and store base
            dest = (r[9:5] == '0) ? `REG_ADDR_W'(1) : r[9:5];
            word = r[17:10];
            writes = 1'b1;
            ins = '0;
            case (r[1:0])
                2'd0: begin
                    ins.r.opcode = OP_RTYPE;
                    ins.r.rs = rs;
                    ins.r.rt = rt;
                    ins.r.rd = dest;
                    ins.r.funct = {3'b000, op};
                    val = alu_model(op, mregs[rs], mregs[rt]);
                end
                2'd1: begin
                    ins.i.opcode = {OP_ORI[5:3], op};
                    ins.i.rs = rs;
                    ins.i.rt = dest;
                    ins.i.imm = r[31:16];
                    val = alu_model(op, mregs[rs], {{(`XLEN-16){r[31]}}, r[31:16]});
                end
                2'd2: begin
                    ins.i.opcode = OP_SW;
                    ins.i.rt = rt;
                    ins.i.imm = {6'b0, word, 2'b00};
                    mmem[word] = mregs[rt];
                    last_store = word;
                    have_store = 1'b1;
                    writes = 1'b0;
                end
                default: begin
                    if (have_store && r[18]) begin
                        word = last_store;
                    end
                    ins.i.opcode = OP_LW;
                    ins.i.rt = dest;
                    ins.i.imm = {6'b0, word, 2'b00};
                    val = mmem[word];
                end
            endcase
            if (writes) begin
                mregs[dest] = val;
                exp_reg[n_exp] = dest;
                exp_data[n_exp] = val;
                exp_k[n_exp] = k;
                n_exp++;
            end
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = writes ? dest : '0;
            prog[k] = ins;
        end
    endtask

    // Instruction memory answers within the cycle and gives zero past the program
    always_comb begin
        fetch_k = int'(instr_addr >> 2);
        instr_data = '0;
        if (fetch_k >= 0 && fetch_k < PROG_LEN) begin
            instr_data = prog[fetch_k];
        end
    end

    always_comb begin
        front_reg = '0;
        front_data = '0;
        front_due = 0;
        if (ret_idx < n_exp) begin
            front_reg = exp_reg[ret_idx];
            front_data = exp_data[ret_idx];
            front_due = due[exp_k[ret_idx]];
        end
    end

    // Enabled-edge count, fetch tags and retire pointer
    always @(posedge clk) begin
        armed <= 1'b1;
        prev_reset <= reset;
        prev_en <= enable;
        prev_addr <= instr_addr;
        cycles <= cycles + 1;
        if (reset && enable) begin
            en_edges <= en_edges + 1;
            if (fetch_k >= 0 && fetch_k < PROG_LEN) begin
                due[fetch_k] <= en_edges + 4;
            end
        end
        if (reset && wb_valid) begin
            ret_idx <= ret_idx + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) armed && !prev_reset |->
                     instr_addr == `RESET_PC && !wb_valid)
        else begin
            errors++;
            $display("Mismatch at %0t: after reset pc %h wb_valid %b, expected pc %h wb_valid 0",
                     $time, $sampled(instr_addr), $sampled(wb_valid), `RESET_PC);
        end

    assert property (@(posedge clk) armed && prev_reset && prev_en |->
                     instr_addr == prev_addr + `XLEN'(4))
        else begin
            errors++;
            $display("Mismatch at %0t: pc %h, expected %h", $time,
                     $sampled(instr_addr), $sampled(prev_addr) + `XLEN'(4));
        end

    assert property (@(posedge clk) armed && prev_reset && !prev_en |->
                     instr_addr == prev_addr)
        else begin
            errors++;
            $display("Mismatch at %0t: pc moved to %h while frozen, expected %h", $time,
                     $sampled(instr_addr), $sampled(prev_addr));
        end

    assert property (@(posedge clk) armed && !enable |-> !wb_valid)
        else begin
            errors++;
            $display("Write-back reported while the pipeline was frozen at %0t", $time);
        end

    assert property (@(posedge clk) armed && wb_valid |-> ret_idx < n_exp)
        else begin
            errors++;
            $display("Unexpected extra write-back to r%0d at %0t", $sampled(wb_reg), $time);
        end

    assert property (@(posedge clk) armed && wb_valid && ret_idx < n_exp |->
                     wb_reg == front_reg && wb_data == front_data)
        else begin
            errors++;
            $display("Mismatch at %0t: r%0d = %h, expected r%0d = %h", $time,
                     $sampled(wb_reg), $sampled(wb_data), $sampled(front_reg),
                     $sampled(front_data));
        end

    assert property (@(posedge clk) armed && wb_valid && ret_idx < n_exp |->
                     en_edges == front_due)
        else begin
            errors++;
            $display("Mismatch at %0t: retired at enabled edge %0d, expected %0d", $time,
                     $sampled(en_edges), $sampled(front_due));
        end

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        seed = 32'h9c6f;
        errors = 0;
        n_exp = 0;
        ret_idx = 0;
        en_edges = 0;
        cycles = 0;
        stall_left = 0;
        armed = 1'b0;
        prev_reset = 1'b0;
        prev_en = 1'b0;
        prev_addr = '0;
        done = 1'b0;
        reset = 1'b0;
        enable = 1'b0;
        for (int k = 0; k < PROG_LEN; k++) begin
            due[k] = -1;
        end
        build_program();

        repeat (10) @(posedge clk);
        reset <= 1'b1;
        enable <= 1'b1;

        while (!done && cycles < MAX_CYCLES) begin
            @(posedge clk);
            if (enable && en_edges == due[PROG_LEN-1]) begin
                // Last instruction leaves write-back on this edge and the rest stays frozen
                enable <= 1'b0;
                done = 1'b1;
            end else if (stall_left > 0) begin
                enable <= 1'b0;
                stall_left = stall_left - 1;
            end else begin
                stim_r = rand32();
                if (stim_r[2:0] == 3'd0) begin
                    enable <= 1'b0;
                    stall_left = int'(stim_r[4:3] % 2'd3);
                end else begin
                    enable <= 1'b1;
                end
            end
        end
        repeat (4) @(posedge clk);

        if (!done) begin
            errors++;
            $display("Timeout: run stopped after %0d cycles with %0d of %0d write-backs seen",
                     cycles, ret_idx, n_exp);
        end
        assert (ret_idx == n_exp)
            else begin
                errors++;
                $display("Write-backs missing: %0d still expected", n_exp - ret_idx);
            end
        for (int k = 0; k < PROG_LEN; k++) begin
            assert (due[k] >= 0)
                else begin
                    errors++;
                    $display("Instruction %0d was never fetched", k);
                end
        end

        $display("Errors: %0d, write-backs checked: %0d of %0d, cycles: %0d",
                 errors, ret_idx, n_exp, cycles);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/stage_ifs.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f src.f --top-module cpu_tb -o cpu_tb_sim
./obj_dir/cpu_tb_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
